//--- Makefile
TOP = tb_cam_sccb_init

.PHONY: all compile run check clean

all: check

compile:
	verilator --binary --assert --top-module $(TOP) -f files.f

run: compile
	./obj_dir/V$(TOP) > run.log 2>&1; cat run.log

check: run
	@if grep -q ">>> PASS" run.log; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see run.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir run.log

//--- files.f
hw/sccb_pkg.sv
hw/cam_init_rom.sv
hw/init_sequencer.sv
hw/sccb_tick_gen.sv
hw/sccb_write_master.sv
hw/cam_sccb_init.sv
test/sccb_bus_monitor.sv
test/tb_cam_sccb_init.sv

//--- hw/cam_init_rom.sv
module cam_init_rom import sccb_pkg::*; (
    input  logic                  clk,
    input  logic [ROM_ADDR_W-1:0] rom_addr,
    output logic [15:0]           rom_data
);

    // Upper byte is the register, lower byte the value
    always_ff @(posedge clk) begin
        case (rom_addr)
            8'd0:  rom_data <= 16'h1280;        // COM7 soft reset
            8'd1:  rom_data <= ROM_DELAY_CODE;  // Let the sensor settle
            8'd2:  rom_data <= 16'h1214;        // COM7 RGB, QVGA
            8'd3:  rom_data <= 16'h1180;        // CLKRC
            8'd4:  rom_data <= 16'h0C04;        // COM3
            8'd5:  rom_data <= 16'h3E19;        // COM14 pclk, no scaling
            8'd6:  rom_data <= 16'h0400;        // COM1 no CCIR656
            8'd7:  rom_data <= 16'h40D0;        // COM15 RGB565 full range
            8'd8:  rom_data <= 16'h3A04;        // TSLB
            8'd9:  rom_data <= 16'h1418;        // COM9 gain ceiling
            // Color matrix
            8'd10: rom_data <= 16'h4FB3;
            8'd11: rom_data <= 16'h50B3;
            8'd12: rom_data <= 16'h5100;
            8'd13: rom_data <= 16'h523D;
            8'd14: rom_data <= 16'h53A7;
            8'd15: rom_data <= 16'h54E4;
            8'd16: rom_data <= 16'h589E;        // Matrix sign bits
            8'd17: rom_data <= 16'h3DC0;        // COM13 gamma on
            // Window and timing
            8'd18: rom_data <= 16'h1715;        // HSTART
            8'd19: rom_data <= 16'h1803;        // HSTOP
            8'd20: rom_data <= 16'h3200;        // HREF
            8'd21: rom_data <= 16'h1903;        // VSTART
            8'd22: rom_data <= 16'h1A7B;        // VSTOP
            8'd23: rom_data <= 16'h0300;        // VREF
            8'd24: rom_data <= 16'h0F41;        // COM6
            8'd25: rom_data <= 16'h1E00;        // MVFP no mirror
            8'd26: rom_data <= 16'h330B;        // CHLF
            8'd27: rom_data <= 16'h3C78;        // COM12
            8'd28: rom_data <= 16'h6900;        // GFIX
            8'd29: rom_data <= 16'h7400;        // REG74
            8'd30: rom_data <= 16'hB084;        // Reserved, color quality
            8'd31: rom_data <= 16'hB10C;        // ABLC1
            8'd32: rom_data <= 16'hB20E;
            8'd33: rom_data <= 16'hB380;        // THL_ST
            // Scaling
            8'd34: rom_data <= 16'h703A;
            8'd35: rom_data <= 16'h7135;
            8'd36: rom_data <= 16'h7211;
            8'd37: rom_data <= 16'h73F1;
            8'd38: rom_data <= 16'hA202;
            // Gamma curve
            8'd39: rom_data <= 16'h7A20;
            8'd40: rom_data <= 16'h7B10;
            8'd41: rom_data <= 16'h7C1E;
            8'd42: rom_data <= 16'h7D35;
            8'd43: rom_data <= 16'h7E5A;
            8'd44: rom_data <= 16'h7F69;
            8'd45: rom_data <= 16'h8076;
            8'd46: rom_data <= 16'h8180;
            8'd47: rom_data <= 16'h8288;
            8'd48: rom_data <= 16'h838F;
            8'd49: rom_data <= 16'h8496;
            8'd50: rom_data <= 16'h85A3;
            8'd51: rom_data <= 16'h86AF;
            8'd52: rom_data <= 16'h87C4;
            8'd53: rom_data <= 16'h88D7;
            8'd54: rom_data <= 16'h89E8;
            // AGC and AEC
            8'd55: rom_data <= 16'h13E0;        // COM8 AGC/AEC off
            8'd56: rom_data <= 16'h0000;        // GAIN
            8'd57: rom_data <= 16'h1000;        // AECH
            8'd58: rom_data <= 16'h0D40;        // COM4
            8'd59: rom_data <= 16'h1418;        // COM9
            8'd60: rom_data <= 16'hA505;        // BD50MAX
            8'd61: rom_data <= 16'hAB07;        // BD60MAX
            8'd62: rom_data <= 16'h2495;        // AEW
            8'd63: rom_data <= 16'h2533;        // AEB
            8'd64: rom_data <= 16'h26E3;        // VPT
            8'd65: rom_data <= 16'h9F78;        // HAECC1
            8'd66: rom_data <= 16'hA068;        // HAECC2
            8'd67: rom_data <= 16'hA103;
            8'd68: rom_data <= 16'hA6D8;        // HAECC3
            8'd69: rom_data <= 16'hA7D8;        // HAECC4
            8'd70: rom_data <= 16'hA8F0;        // HAECC5
            8'd71: rom_data <= 16'hA990;        // HAECC6
            8'd72: rom_data <= 16'hAA94;        // HAECC7
            8'd73: rom_data <= 16'h13E7;        // COM8 AGC/AEC back on
            8'd74: rom_data <= 16'h6907;        // GFIX
            default: rom_data <= ROM_END_CODE;
        endcase
    end

endmodule

//--- hw/cam_sccb_init.sv
module cam_sccb_init import sccb_pkg::*; #(
    parameter int CLK_DIV      = 62,
    parameter int DELAY_CYCLES = 1_000_000
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic busy,
    output logic done,
    output logic scl,
    output logic sda_out,
    output logic sda_oe
);

    logic [ROM_ADDR_W-1:0] rom_addr;
    logic [15:0]           rom_data;
    logic                  wr_start;
    logic [7:0]            reg_addr;
    logic [7:0]            reg_data;
    logic                  wr_busy;
    logic                  wr_done;
    logic                  tick;

    cam_init_rom i_cam_init_rom (
        .clk      (clk),
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

    init_sequencer #(
        .DELAY_CYCLES (DELAY_CYCLES)
    ) i_init_sequencer (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .wr_start (wr_start),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .wr_busy  (wr_busy),
        .wr_done  (wr_done),
        .busy     (busy),
        .done     (done)
    );

    // Runs only while a write is on the bus
    sccb_tick_gen #(
        .CLK_DIV (CLK_DIV)
    ) i_sccb_tick_gen (
        .clk    (clk),
        .reset  (reset),
        .enable (wr_busy),
        .tick   (tick)
    );

    sccb_write_master i_sccb_write_master (
        .clk      (clk),
        .reset    (reset),
        .wr_start (wr_start),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .tick     (tick),
        .wr_busy  (wr_busy),
        .wr_done  (wr_done),
        .scl      (scl),
        .sda_out  (sda_out),
        .sda_oe   (sda_oe)
    );

endmodule

//--- hw/init_sequencer.sv
module init_sequencer import sccb_pkg::*; #(
    parameter int DELAY_CYCLES = 1_000_000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    output logic [ROM_ADDR_W-1:0] rom_addr,
    input  logic [15:0]           rom_data,
    output logic                  wr_start,
    output logic [7:0]            reg_addr,
    output logic [7:0]            reg_data,
    input  logic                  wr_busy,
    input  logic                  wr_done,
    output logic                  busy,
    output logic                  done
);

    localparam int DLY_W = $clog2(DELAY_CYCLES + 1);

    seq_state_e       state;
    logic [DLY_W-1:0] delay_cnt;

    assign busy = (state != seq_idle) && (state != seq_finished);
    assign done = (state == seq_finished);

    // Register and value for the write launched after decode
    always_ff @(posedge clk) begin
        if (state == seq_decode) begin
            reg_addr <= rom_data[15:8];
            reg_data <= rom_data[7:0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Entry walk
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= seq_idle;
            rom_addr  <= '0;
            wr_start  <= 1'b0;
            delay_cnt <= '0;
        end else begin
            wr_start <= 1'b0;                       // One-cycle launch
            case (state)
                seq_idle, seq_finished: begin
                    if (start) begin
                        rom_addr <= '0;             // Always restart from entry 0
                        state    <= seq_fetch;
                    end
                end
                seq_fetch: state <= seq_decode;     // ROM latency
                seq_decode: begin
                    if (rom_data == ROM_END_CODE) begin
                        state <= seq_finished;
                    end else if (rom_data == ROM_DELAY_CODE) begin
                        delay_cnt <= DLY_W'(DELAY_CYCLES - 1);
                        state     <= seq_delay;
                    end else if (!wr_busy) begin
                        wr_start <= 1'b1;
                        state    <= seq_wait_write;
                    end else begin
                        state <= seq_write;
                    end
                end
                seq_write: begin
                    if (!wr_busy) begin
                        wr_start <= 1'b1;
                        state    <= seq_wait_write;
                    end
                end
                seq_wait_write: begin
                    if (wr_done) begin
                        rom_addr <= rom_addr + 1'b1;
                        state    <= seq_fetch;
                    end
                end
                seq_delay: begin
                    if (delay_cnt == '0) begin
                        rom_addr <= rom_addr + 1'b1;
                        state    <= seq_fetch;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    // Never launch into a write master that is still on the bus
    launch_when_free: assert property (@(posedge clk) disable iff (reset)
        wr_start |-> !wr_busy);

endmodule

//--- hw/sccb_pkg.sv
package sccb_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus and table constants
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0] SCCB_DEV_ID = 8'h42;       // Camera write ID

    localparam int ROM_ADDR_W = 8;                     // Entry index width

    // Special table words, never sent on the bus
    localparam logic [15:0] ROM_DELAY_CODE = 16'hFFF0;  // Wait instead of write
    localparam logic [15:0] ROM_END_CODE   = 16'hFFFF;  // Table finished

    ////////////////////////////////////////////////////////////////////////////
    // State encodings
    ////////////////////////////////////////////////////////////////////////////

    // Init sequencer
    typedef enum logic [2:0] {
        seq_idle,           // Waiting for start
        seq_fetch,          // ROM address presented
        seq_decode,         // ROM word valid, classify it
        seq_write,          // Waiting for a free write master
        seq_wait_write,     // Write in flight
        seq_delay,          // Counting down a delay entry
        seq_finished        // End code seen, done held
    } seq_state_e;

    // Write master
    typedef enum logic [1:0] {
        bus_idle,           // Bus released high
        bus_start,          // sda low, scl still high
        bus_shift,          // 27 bit slots
        bus_stop            // Stop condition
    } bus_state_e;

endpackage

//--- hw/sccb_tick_gen.sv
module sccb_tick_gen #(
    parameter int CLK_DIV = 62
) (
    input  logic clk,
    input  logic reset,
    input  logic enable,
    output logic tick
);

    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [CNT_W-1:0] cnt;

    // Quarter-bit strobe, phase restarts with every write
    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == CNT_W'(CLK_DIV - 1)) begin
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

//--- hw/sccb_write_master.sv
module sccb_write_master import sccb_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       wr_start,
    input  logic [7:0] reg_addr,
    input  logic [7:0] reg_data,
    input  logic       tick,
    output logic       wr_busy,
    output logic       wr_done,
    output logic       scl,
    output logic       sda_out,
    output logic       sda_oe
);

    localparam int FRAME_BITS = 27;

    bus_state_e            state;
    logic [4:0]            bit_cnt;     // Slot within the frame
    logic [1:0]            quarter;     // Quarter within a slot
    logic [FRAME_BITS-1:0] frame;
    logic                  dont_care;

    // Ninth bit of each phase, bus released
    assign dont_care = (bit_cnt == 5'd8) || (bit_cnt == 5'd17) || (bit_cnt == 5'd26);

    ////////////////////////////////////////////////////////////////////////////
    // Frame shift register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == bus_idle && wr_start) begin
            frame <= {SCCB_DEV_ID, 1'b0, reg_addr, 1'b0, reg_data, 1'b0};
        end else if (state == bus_shift && tick && quarter == 2'd0) begin
            frame <= {frame[FRAME_BITS-2:0], 1'b0};  // MSB first
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus sequencing, one step per tick
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= bus_idle;
            bit_cnt <= '0;
            quarter <= '0;
            wr_busy <= 1'b0;
            wr_done <= 1'b0;
            scl     <= 1'b1;
            sda_out <= 1'b1;
            sda_oe  <= 1'b1;
        end else begin
            wr_done <= 1'b0;
            case (state)
                bus_idle: begin
                    if (wr_start) begin
                        sda_out <= 1'b0;            // Start: sda falls, scl high
                        wr_busy <= 1'b1;
                        state   <= bus_start;
                    end
                end
                bus_start: begin
                    if (tick) begin
                        scl     <= 1'b0;
                        bit_cnt <= '0;
                        quarter <= '0;
                        state   <= bus_shift;
                    end
                end
                bus_shift: begin
                    if (tick) begin
                        quarter <= quarter + 1'b1;
                        case (quarter)
                            2'd0: begin
                                sda_out <= frame[FRAME_BITS-1];  // scl is low here
                                sda_oe  <= !dont_care;
                            end
                            2'd1, 2'd2: scl <= 1'b1;
                            default: begin
                                scl <= 1'b0;
                                if (bit_cnt == 5'(FRAME_BITS - 1)) begin
                                    state <= bus_stop;
                                end else begin
                                    bit_cnt <= bit_cnt + 1'b1;
                                end
                            end
                        endcase
                    end
                end
                bus_stop: begin
                    if (tick) begin
                        quarter <= quarter + 1'b1;
                        case (quarter)
                            2'd0: begin
                                sda_out <= 1'b0;    // Drive low again before stop
                                sda_oe  <= 1'b1;
                            end
                            2'd1: scl <= 1'b1;
                            default: begin
                                sda_out <= 1'b1;    // Stop: sda rises, scl high
                                wr_busy <= 1'b0;
                                wr_done <= 1'b1;
                                state   <= bus_idle;
                            end
                        endcase
                    end
                end
                default: state <= bus_idle;
            endcase
        end
    end

    // Data moves only in the low phase of scl between start and stop
    sda_setup_low: assert property (@(posedge clk) disable iff (reset)
        (state == bus_shift && $changed(sda_out)) |-> (!scl && $stable(scl)));

endmodule

//--- test/sccb_bus_monitor.sv
module sccb_bus_monitor import sccb_pkg::*; #(
    parameter int DELAY_CYCLES = 1_000_000
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic busy,
    input  logic done,
    input  logic scl,
    input  logic sda_out,
    input  logic sda_oe,
    input  logic end_of_test,
    input  int   exp_runs,
    output int   err_cnt
);

    localparam int NUM_WRITES = 74;

    // Register/value pairs in table order without the delay entry
    localparam logic [15:0] EXP_PAIRS [NUM_WRITES] = '{
        16'h1280, 16'h1214, 16'h1180, 16'h0C04, 16'h3E19, 16'h0400, 16'h40D0, 16'h3A04,
        16'h1418, 16'h4FB3, 16'h50B3, 16'h5100, 16'h523D, 16'h53A7, 16'h54E4, 16'h589E,
        16'h3DC0, 16'h1715, 16'h1803, 16'h3200, 16'h1903, 16'h1A7B, 16'h0300, 16'h0F41,
        16'h1E00, 16'h330B, 16'h3C78, 16'h6900, 16'h7400, 16'hB084, 16'hB10C, 16'hB20E,
        16'hB380, 16'h703A, 16'h7135, 16'h7211, 16'h73F1, 16'hA202, 16'h7A20, 16'h7B10,
        16'h7C1E, 16'h7D35, 16'h7E5A, 16'h7F69, 16'h8076, 16'h8180, 16'h8288, 16'h838F,
        16'h8496, 16'h85A3, 16'h86AF, 16'h87C4, 16'h88D7, 16'h89E8, 16'h13E0, 16'h0000,
        16'h1000, 16'h0D40, 16'h1418, 16'hA505, 16'hAB07, 16'h2495, 16'h2533, 16'h26E3,
        16'h9F78, 16'hA068, 16'hA103, 16'hA6D8, 16'hA7D8, 16'hA8F0, 16'hA990, 16'hAA94,
        16'h13E7, 16'h6907
    };

    logic        sda_line;
    logic        prev_scl  = 1'b1;
    logic        prev_sda  = 1'b1;
    logic        prev_done = 1'b0;
    logic        in_frame  = 1'b0;
    logic        started   = 1'b0;
    logic        end_seen  = 1'b0;
    logic [26:0] bits      = '0;
    int          bit_cnt    = 0;
    int          trans_idx  = 0;
    int          since_stop = 0;
    int          run_cnt    = 0;
    int          errors     = 0;

    assign sda_line = sda_oe ? sda_out : 1'b1;     // Pull-up while released
    assign err_cnt  = errors;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Bus monitor: %s", what);
        errors++;
    endtask

    task automatic close_frame();
        logic [15:0] pair;
        pair = (trans_idx < NUM_WRITES) ? EXP_PAIRS[7'(trans_idx)] : 16'h0000;
        compare_value("scl_rises", 32'(bit_cnt), 32'd28);      // 27 slots plus stop clock
        compare_value("dev_id", 32'(bits[26:19]), 32'(SCCB_DEV_ID));
        if (trans_idx >= NUM_WRITES) begin
            report_failure("transaction seen after the last table entry");
        end else begin
            compare_value("reg_addr", 32'(bits[17:10]), 32'(pair[15:8]));
            compare_value("reg_data", 32'(bits[8:1]), 32'(pair[7:0]));
        end
        trans_idx++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus decode on the falling clock edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!reset) begin
            if (!started) begin                         // Idle levels before first start
                compare_value("scl", 32'(scl), 32'd1);
                compare_value("sda_out", 32'(sda_out), 32'd1);
                compare_value("sda_oe", 32'(sda_oe), 32'd1);
                compare_value("busy", 32'(busy), 32'd0);
                compare_value("done", 32'(done), 32'd0);
            end
            if (start && !busy) begin                   // Accepted start begins a new run
                started   = 1'b1;
                trans_idx = 0;
            end
            if (done && (scl != prev_scl || sda_line != prev_sda)) begin
                report_failure("bus activity after done");
            end
            if (prev_scl && scl && prev_sda && !sda_line) begin
                if (in_frame) begin
                    report_failure("start condition inside a transaction");
                end
                if (trans_idx == 1 && since_stop < DELAY_CYCLES) begin
                    $display("ERROR delay_gap got %0h expected %0h or more",
                             since_stop, DELAY_CYCLES);
                    errors++;
                end
                in_frame = 1'b1;
                bit_cnt  = 0;
            end else if (prev_scl && scl && !prev_sda && sda_line) begin
                if (in_frame) begin
                    close_frame();
                end else begin
                    report_failure("stop condition outside a transaction");
                end
                compare_value("sda_oe", 32'(sda_oe), 32'd1);
                in_frame   = 1'b0;
                since_stop = 0;
            end else if (!prev_scl && scl && in_frame) begin
                compare_value("sda_oe", 32'(sda_oe), 32'(bit_cnt % 9 != 8));
                if (bit_cnt < 27) begin
                    bits = {bits[25:0], sda_line};
                end
                bit_cnt++;
            end
            if (done && !prev_done) begin               // End of one run
                compare_value("trans_cnt", 32'(trans_idx), 32'(NUM_WRITES));
                compare_value("busy", 32'(busy), 32'd0);
                run_cnt++;
            end
            if (end_of_test && !end_seen) begin
                end_seen = 1'b1;
                compare_value("runs", 32'(run_cnt), 32'(exp_runs));
            end
            if (!in_frame) begin
                since_stop++;
            end
        end
        prev_scl  = scl;
        prev_sda  = sda_line;
        prev_done = done;
    end

endmodule

//--- test/tb_cam_sccb_init.sv
module tb_cam_sccb_init;

    localparam int CLK_DIV      = 4;
    localparam int DELAY_CYCLES = 200;
    localparam int CLK_PERIOD   = 8;
    localparam int NUM_EVENTS   = 3;
    // Two runs of 74 writes at 112 ticks each, delays included, 50% margin
    localparam int RUN_CYCLES   = 74 * 112 * CLK_DIV + DELAY_CYCLES;
    localparam int LIMIT_CYCLES = 2 * RUN_CYCLES * 3 / 2;

    // Start events and whether each one should begin a new run
    localparam logic WHILE_BUSY [NUM_EVENTS] = '{1'b0, 1'b1, 1'b0};
    localparam logic NEW_RUN    [NUM_EVENTS] = '{1'b1, 1'b0, 1'b1};

    logic clk;
    logic reset;
    logic start;
    logic busy;
    logic done;
    logic scl;
    logic sda_out;
    logic sda_oe;
    logic end_of_test;
    int   exp_runs;
    int   mon_errors;
    int   tb_errors;

    cam_sccb_init #(
        .CLK_DIV      (CLK_DIV),
        .DELAY_CYCLES (DELAY_CYCLES)
    ) i_cam_sccb_init (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe)
    );

    sccb_bus_monitor #(
        .DELAY_CYCLES (DELAY_CYCLES)
    ) i_sccb_bus_monitor (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .busy        (busy),
        .done        (done),
        .scl         (scl),
        .sda_out     (sda_out),
        .sda_oe      (sda_oe),
        .end_of_test (end_of_test),
        .exp_runs    (exp_runs),
        .err_cnt     (mon_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("Timeout: init sequence still running after %0d cycles", LIMIT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Start events
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int gap;
        void'($urandom(73));
        reset       = 1'b1;
        start       = 1'b0;
        end_of_test = 1'b0;
        exp_runs    = 0;
        tb_errors   = 0;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < NUM_EVENTS; i++) begin
            while (!WHILE_BUSY[i] && busy) begin    // Previous run must be over
                @(posedge clk);
                #1;
            end
            gap = int'($urandom_range(32, 1));
            repeat (gap) @(posedge clk);
            #1;
            if (WHILE_BUSY[i] != busy) begin
                $display("Start event %0d did not meet the intended busy state", i);
                tb_errors++;
            end
            start = 1'b1;
            @(posedge clk);
            #1 start = 1'b0;
            if (NEW_RUN[i]) begin
                exp_runs++;
            end
        end
        while (!done) begin
            @(posedge clk);
            #1;
        end
        repeat (300) @(posedge clk);                // Bus must stay quiet
        #1 end_of_test = 1'b1;
        repeat (2) @(posedge clk);
        $display("Errors: monitor %0d, testbench %0d", mon_errors, tb_errors);
        if (mon_errors == 0 && tb_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
